// ==== hdl/tof_hist_cfg.svh ====
`ifndef TOF_HIST_CFG_SVH
`define TOF_HIST_CFG_SVH

// raw photon timestamp from the TDC
`define TS_W 8

// histogram bin index, one nibble of the timestamp
`define BIN_W 4

// pixels per frame and their index width
`define NUM_PIX 4
`define PIX_W 2

// samples per pixel in one acquisition
`define SAMP_PER_PIX 4

// acquisitions per frame
`define NUM_ACQ 3

// bin counter, 12 hits per pixel at most
`define CNT_W 4

// APB bus widths
`define APB_AW 8
`define APB_DW 32

`endif

// ==== hdl/tof_hist_pkg.sv ====
`default_nettype none

`include "tof_hist_cfg.svh"

package tof_hist_pkg;

    // which timestamp nibble becomes the bin
    typedef enum logic {
        MODE_COARSE = 1'b0,
        MODE_FINE   = 1'b1
    } bin_mode_e;

    // register map offsets
    // peak registers continue at 4-byte steps after REG_PEAK0
    typedef enum logic [`APB_AW-1:0] {
        REG_CTRL   = `APB_AW'h00,
        REG_STATUS = `APB_AW'h04,
        REG_PEAK0  = `APB_AW'h10
    } reg_ofs_e;

endpackage

`default_nettype wire

// ==== hdl/sample_binner.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module sample_binner
    import tof_hist_pkg::*;
(
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       ts_valid,
    input  logic [`TS_W-1:0]           ts,
    input  logic                       enable,
    input  bin_mode_e                  mode,
    input  logic [`NUM_PIX*`BIN_W-1:0] peak_coarse,
    output logic                       s1_valid,
    output logic [`PIX_W-1:0]          s1_pix,
    output logic [`BIN_W-1:0]          s1_bin,
    output logic                       s1_count_en,
    output logic                       s1_last
);

    localparam int SAMP_W = $clog2(`SAMP_PER_PIX);
    localparam int ACQ_W  = $clog2(`NUM_ACQ);

    // sequence position of the next accepted sample
    logic [SAMP_W-1:0] samp_cnt;
    logic [`PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;
    logic              accept;
    logic              samp_wrap;
    logic              pix_wrap;
    logic              acq_wrap;
    logic              first_samp;
    logic              last_samp;
    bin_mode_e         frame_mode;

    // captured sample waiting for binning
    logic              cap_valid;
    logic [`TS_W-1:0]  cap_ts;
    logic [`PIX_W-1:0] cap_pix;
    logic              cap_last;

    logic [`BIN_W-1:0] ts_hi;
    logic [`BIN_W-1:0] ts_lo;
    logic [`BIN_W-1:0] pix_peak;
    logic [`BIN_W-1:0] bin;
    logic              in_win;

    // disabled samples are dropped before the sequence
    assign accept     = ts_valid && enable;
    assign samp_wrap  = samp_cnt == SAMP_W'(`SAMP_PER_PIX - 1);
    assign pix_wrap   = pix_cnt == `PIX_W'(`NUM_PIX - 1);
    assign acq_wrap   = acq_cnt == ACQ_W'(`NUM_ACQ - 1);
    assign first_samp = (samp_cnt == '0) && (pix_cnt == '0) && (acq_cnt == '0);
    assign last_samp  = samp_wrap && pix_wrap && acq_wrap;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            samp_cnt   <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            frame_mode <= MODE_COARSE;
            cap_valid  <= 1'b0;
        end else begin
            cap_valid <= accept;
            if (accept) begin
                // mode is frozen for the whole frame
                if (first_samp) begin
                    frame_mode <= mode;
                end
                if (!samp_wrap) begin
                    samp_cnt <= samp_cnt + 1'b1;
                end else begin
                    samp_cnt <= '0;
                    if (!pix_wrap) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end else begin
                        pix_cnt <= '0;
                        acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_ts   <= ts;
            cap_pix  <= pix_cnt;
            cap_last <= last_samp;
        end
    end

    // nibble split and fine window against the stored coarse peak
    assign ts_hi    = cap_ts[`TS_W-1 -: `BIN_W];
    assign ts_lo    = cap_ts[`BIN_W-1:0];
    assign pix_peak = peak_coarse[cap_pix*`BIN_W +: `BIN_W];
    assign bin      = (frame_mode == MODE_FINE) ? ts_lo : ts_hi;
    assign in_win   = (frame_mode == MODE_COARSE) || (ts_hi == pix_peak);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            s1_pix      <= cap_pix;
            s1_bin      <= bin;
            s1_count_en <= in_win;
            s1_last     <= cap_last;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hist_accumulator.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module hist_accumulator (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              s1_valid,
    input  logic [`PIX_W-1:0] s1_pix,
    input  logic [`BIN_W-1:0] s1_bin,
    input  logic              s1_count_en,
    input  logic              s1_last,
    output logic              s2_valid,
    output logic [`PIX_W-1:0] s2_pix,
    output logic [`BIN_W-1:0] s2_bin,
    output logic [`CNT_W-1:0] s2_count,
    output logic              s2_last
);

    // one histogram per pixel, pixel index in the upper address bits
    localparam int HIST_DEPTH = `NUM_PIX * (1 << `BIN_W);
    localparam int IDX_W      = `PIX_W + `BIN_W;

    logic [`CNT_W-1:0]     hist_mem [HIST_DEPTH];
    // a clear bit means the bin holds no hits this frame
    logic [HIST_DEPTH-1:0] hist_vld;

    // write-back of the count held on s2
    logic                  wb_en;
    logic [IDX_W-1:0]      wb_idx;

    logic [IDX_W-1:0]      rd_idx;
    logic [`CNT_W-1:0]     rd_cnt;
    logic                  fwd_hit;
    logic [`CNT_W-1:0]     base_cnt;
    logic [`CNT_W-1:0]     next_cnt;

    assign rd_idx = {s1_pix, s1_bin};
    assign wb_idx = {s2_pix, s2_bin};

    // stale array data is masked by the valid bit
    assign rd_cnt = hist_vld[rd_idx] ? hist_mem[rd_idx] : '0;

    // array is written one cycle late
    // so a repeat hit takes the count straight off s2
    assign fwd_hit  = wb_en && (wb_idx == rd_idx);
    assign base_cnt = fwd_hit ? s2_count : rd_cnt;
    assign next_cnt = s1_count_en ? base_cnt + 1'b1 : '0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wb_en    <= 1'b0;
            hist_vld <= '0;
        end else begin
            // last sample never writes back
            // its frame is already closed
            wb_en <= s1_valid && s1_count_en && !s1_last;
            if (s1_valid && s1_last) begin
                // whole frame clears at once
                hist_vld <= '0;
            end else if (wb_en) begin
                hist_vld[wb_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en) begin
            hist_mem[wb_idx] <= s2_count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // updated single-bin count to the peak stage
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_pix   <= s1_pix;
            s2_bin   <= s1_bin;
            s2_count <= next_cnt;
            s2_last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/peak_finder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module peak_finder
    import tof_hist_pkg::*;
(
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       s2_valid,
    input  logic [`PIX_W-1:0]          s2_pix,
    input  logic [`BIN_W-1:0]          s2_bin,
    input  logic [`CNT_W-1:0]          s2_count,
    input  logic                       s2_last,
    input  bin_mode_e                  mode,
    output logic [`NUM_PIX*`BIN_W-1:0] peak_coarse,
    output logic [`NUM_PIX*`BIN_W-1:0] peak_fine,
    output logic [`NUM_PIX*`CNT_W-1:0] peak_cnt,
    output logic                       frame_done
);

    // running maximum per pixel
    logic [`BIN_W-1:0] run_bin [`NUM_PIX];
    logic [`CNT_W-1:0] run_cnt [`NUM_PIX];
    // maximum including the sample now on s2
    logic [`BIN_W-1:0] fin_bin [`NUM_PIX];
    logic [`CNT_W-1:0] fin_cnt [`NUM_PIX];
    logic              upd;

    // ctrl mode delayed to line up with stage 1's latch point
    bin_mode_e         mode_pipe [3];
    bin_mode_e         frame_mode;
    bin_mode_e         cur_mode;
    logic              frame_open;

    // strictly greater, so the first bin to a count holds it
    assign upd = s2_valid && (s2_count > run_cnt[s2_pix]);

    always_comb begin
        for (int p = 0; p < `NUM_PIX; p++) begin
            if (upd && (s2_pix == `PIX_W'(p))) begin
                fin_bin[p] = s2_bin;
                fin_cnt[p] = s2_count;
            end else begin
                fin_bin[p] = run_bin[p];
                fin_cnt[p] = run_cnt[p];
            end
        end
    end

    // first sample of a frame picks the mode up
    assign cur_mode = frame_open ? frame_mode : mode_pipe[2];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < 3; i++) begin
                mode_pipe[i] <= MODE_COARSE;
            end
            frame_mode <= MODE_COARSE;
            frame_open <= 1'b0;
        end else begin
            mode_pipe[0] <= mode;
            mode_pipe[1] <= mode_pipe[0];
            mode_pipe[2] <= mode_pipe[1];
            if (s2_valid) begin
                frame_mode <= cur_mode;
                frame_open <= !s2_last;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `NUM_PIX; p++) begin
                run_bin[p] <= '0;
                run_cnt[p] <= '0;
            end
            peak_coarse <= '0;
            peak_fine   <= '0;
            peak_cnt    <= '0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= s2_valid && s2_last;
            if (s2_valid && s2_last) begin
                // latch peaks and restart the running state
                for (int p = 0; p < `NUM_PIX; p++) begin
                    if (cur_mode == MODE_FINE) begin
                        peak_fine[p*`BIN_W +: `BIN_W] <= fin_bin[p];
                    end else begin
                        peak_coarse[p*`BIN_W +: `BIN_W] <= fin_bin[p];
                    end
                    peak_cnt[p*`CNT_W +: `CNT_W] <= fin_cnt[p];
                    run_bin[p] <= '0;
                    run_cnt[p] <= '0;
                end
            end else if (upd) begin
                run_bin[s2_pix] <= s2_bin;
                run_cnt[s2_pix] <= s2_count;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hist_apb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module hist_apb_regs
    import tof_hist_pkg::*;
(
    input  logic                       clk,
    input  logic                       combin_res,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_AW-1:0]         paddr,
    input  logic [`APB_DW-1:0]         pwdata,
    input  logic [`NUM_PIX*`BIN_W-1:0] peak_coarse,
    input  logic [`NUM_PIX*`BIN_W-1:0] peak_fine,
    input  logic [`NUM_PIX*`CNT_W-1:0] peak_cnt,
    input  logic                       frame_done,
    output logic [`APB_DW-1:0]         prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       enable,
    output bin_mode_e                  mode
);

    // first address past the peak block
    localparam logic [`APB_AW-1:0] PEAK_END = REG_PEAK0 + `APB_AW'(4 * `NUM_PIX);

    logic              access;
    logic              wr_en;
    logic              hit_ctrl;
    logic              hit_status;
    logic              hit_peak;
    logic [`PIX_W-1:0] peak_sel;
    logic              done_flag;
    logic [7:0]        frame_cnt;
    logic [`APB_DW-1:0] rd_data;

    // access phase of a transfer
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    // address decode
    assign hit_ctrl   = paddr == REG_CTRL;
    assign hit_status = paddr == REG_STATUS;
    assign hit_peak   = (paddr >= REG_PEAK0) && (paddr < PEAK_END) && (paddr[1:0] == 2'b00);
    assign peak_sel   = paddr[`PIX_W+1:2];

    always_comb begin
        rd_data = '0;
        if (hit_ctrl) begin
            rd_data[0] = enable;
            rd_data[1] = mode;
        end else if (hit_status) begin
            rd_data[0]    = done_flag;
            rd_data[15:8] = frame_cnt;
        end else if (hit_peak) begin
            rd_data[3:0]  = peak_coarse[peak_sel*`BIN_W +: `BIN_W];
            rd_data[7:4]  = peak_fine[peak_sel*`BIN_W +: `BIN_W];
            rd_data[11:8] = peak_cnt[peak_sel*`CNT_W +: `CNT_W];
        end
    end

    // zero wait states
    assign pready  = 1'b1;
    assign prdata  = (psel && !pwrite) ? rd_data : '0;
    assign pslverr = access && !(hit_ctrl || hit_status || hit_peak);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            enable    <= 1'b0;
            mode      <= MODE_COARSE;
            done_flag <= 1'b0;
            frame_cnt <= '0;
        end else begin
            if (wr_en && hit_ctrl) begin
                enable <= pwdata[0];
                mode   <= bin_mode_e'(pwdata[1]);
            end
            // a new frame beats a clear in the same cycle
            if (frame_done) begin
                done_flag <= 1'b1;
                frame_cnt <= frame_cnt + 1'b1;
            end else if (wr_en && hit_status && pwdata[0]) begin
                done_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tof_hist_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module tof_hist_top
    import tof_hist_pkg::*;
(
    input  logic               clk,
    input  logic               combin_res,
    input  logic               ts_valid,
    input  logic [`TS_W-1:0]   ts,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [`APB_DW-1:0] pwdata,
    output logic [`APB_DW-1:0] prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               frame_done
);

    // control from the register block
    logic                       enable;
    bin_mode_e                  mode;

    // stage 1 to stage 2
    logic                       s1_valid;
    logic [`PIX_W-1:0]          s1_pix;
    logic [`BIN_W-1:0]          s1_bin;
    logic                       s1_count_en;
    logic                       s1_last;

    // stage 2 to stage 3
    logic                       s2_valid;
    logic [`PIX_W-1:0]          s2_pix;
    logic [`BIN_W-1:0]          s2_bin;
    logic [`CNT_W-1:0]          s2_count;
    logic                       s2_last;

    // latched peaks, also fed back for the fine window
    logic [`NUM_PIX*`BIN_W-1:0] peak_coarse;
    logic [`NUM_PIX*`BIN_W-1:0] peak_fine;
    logic [`NUM_PIX*`CNT_W-1:0] peak_cnt;

    sample_binner u_binner (
        .clk         (clk),
        .combin_res  (combin_res),
        .ts_valid    (ts_valid),
        .ts          (ts),
        .enable      (enable),
        .mode        (mode),
        .peak_coarse (peak_coarse),
        .s1_valid    (s1_valid),
        .s1_pix      (s1_pix),
        .s1_bin      (s1_bin),
        .s1_count_en (s1_count_en),
        .s1_last     (s1_last)
    );

    hist_accumulator u_accum (
        .clk         (clk),
        .combin_res  (combin_res),
        .s1_valid    (s1_valid),
        .s1_pix      (s1_pix),
        .s1_bin      (s1_bin),
        .s1_count_en (s1_count_en),
        .s1_last     (s1_last),
        .s2_valid    (s2_valid),
        .s2_pix      (s2_pix),
        .s2_bin      (s2_bin),
        .s2_count    (s2_count),
        .s2_last     (s2_last)
    );

    peak_finder u_peak (
        .clk         (clk),
        .combin_res  (combin_res),
        .s2_valid    (s2_valid),
        .s2_pix      (s2_pix),
        .s2_bin      (s2_bin),
        .s2_count    (s2_count),
        .s2_last     (s2_last),
        .mode        (mode),
        .peak_coarse (peak_coarse),
        .peak_fine   (peak_fine),
        .peak_cnt    (peak_cnt),
        .frame_done  (frame_done)
    );

    hist_apb_regs u_regs (
        .clk         (clk),
        .combin_res  (combin_res),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .peak_coarse (peak_coarse),
        .peak_fine   (peak_fine),
        .peak_cnt    (peak_cnt),
        .frame_done  (frame_done),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .enable      (enable),
        .mode        (mode)
    );

endmodule

`default_nettype wire

// ==== tb/tof_hist_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module tof_hist_assertions (
    input logic               clk,
    input logic               combin_res,
    input logic               s2_valid,
    input logic [`CNT_W-1:0]  s2_count,
    input logic               frame_done,
    input logic               psel,
    input logic               penable,
    input logic [`APB_AW-1:0] paddr,
    input logic               pslverr
);

    // hits one pixel can collect in a frame
    localparam int PIX_SAMPLES = `SAMP_PER_PIX * `NUM_ACQ;

    // no bin can hold more than its pixel's frame total
    a_count_bound: assert property (@(posedge clk) disable iff (!combin_res)
        s2_valid |-> (s2_count <= `CNT_W'(PIX_SAMPLES)))
        else $error("s2_count above the per-pixel frame total");

    // interrupt is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done)
        else $error("frame_done high in two consecutive cycles");

    // error response only in the access phase to an unmapped address
    a_slverr_phase: assert property (@(posedge clk) disable iff (!combin_res)
        pslverr |-> (psel && penable
                     && !(paddr inside {8'h00, 8'h04, 8'h10, 8'h14, 8'h18, 8'h1c})))
        else $error("pslverr outside an access to an unmapped address");

endmodule

`default_nettype wire

// ==== tb/tof_hist_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tof_hist_cfg.svh"

module tof_hist_tb;

    // samples in one acquisition line of the tests file
    localparam int ACQ_SAMPLES = `NUM_PIX * `SAMP_PER_PIX;
    localparam int WAIT_LIMIT  = 64;

    logic               clk = 1'b0;
    logic               combin_res;
    logic               ts_valid;
    logic [`TS_W-1:0]   ts;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [`APB_DW-1:0] pwdata;
    logic [`APB_DW-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               frame_done;

    int                 checks;
    int                 errors;
    int                 timeouts;
    logic [31:0]        lcg_state;

    tof_hist_top u_dut (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .ts         (ts),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .frame_done (frame_done)
    );

    bind tof_hist_top tof_hist_assertions u_assert (
        .clk        (clk),
        .combin_res (combin_res),
        .s2_valid   (s2_valid),
        .s2_count   (s2_count),
        .frame_done (frame_done),
        .psel       (psel),
        .penable    (penable),
        .paddr      (paddr),
        .pslverr    (pslverr)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // 0 to 3 idle cycles between samples
    function automatic int next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        ts_valid <= 1'b0;
    endtask

    // pixel 0 first with four timestamps per pixel
    // msb byte holds the earliest sample
    task automatic send_acq(input logic gapped, input logic [ACQ_SAMPLES*`TS_W-1:0] acq);
        int gap;
        for (int i = 0; i < ACQ_SAMPLES; i++) begin
            gap = gapped ? next_gap() : 0;
            repeat (gap) idle_cycle();
            @(posedge clk);
            ts_valid <= 1'b1;
            ts       <= acq[(ACQ_SAMPLES - i) * `TS_W - 1 -: `TS_W];
        end
    endtask

    // setup then access phase
    // response sampled at the falling edge
    task automatic apb_access(input logic wr, input logic [`APB_AW-1:0] addr,
                              input logic [`APB_DW-1:0] data, input logic exp_err);
        int waited;
        @(posedge clk);
        ts_valid <= 1'b0;
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= wr;
        paddr    <= addr;
        pwdata   <= data;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: pready stayed low at address 0x%02h", addr);
            timeouts++;
            errors++;
        end else begin
            if (!wr) begin
                check_equal(prdata, data, $sformatf("prdata at 0x%02h", addr));
            end
            check_equal(32'(pslverr), 32'(exp_err), $sformatf("pslverr at 0x%02h", addr));
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // counts rising edges from the last sample drive to the pulse
    task automatic wait_frame_done(input int exp_lat);
        int lat;
        lat = 0;
        @(negedge clk);
        while (!frame_done && lat < WAIT_LIMIT) begin
            @(posedge clk);
            ts_valid <= 1'b0;
            lat++;
            @(negedge clk);
        end
        if (!frame_done) begin
            $display("timeout: frame_done did not pulse within %0d cycles", WAIT_LIMIT);
            timeouts++;
            errors++;
        end else begin
            check_equal(32'(lat), 32'(exp_lat), "frame_done latency");
        end
    endtask

    initial begin : run_tests
        int                 fd;
        string              line;
        string              rest;
        byte                op;
        logic [`APB_AW-1:0] addr;
        logic [`APB_DW-1:0] data;
        logic [31:0]        w0;
        logic [31:0]        w1;
        logic [31:0]        w2;
        logic [31:0]        w3;
        logic               err;
        int                 gapped;
        int                 reps;
        int                 lat;
        logic               ok;
        combin_res <= 1'b0;
        ts_valid   <= 1'b0;
        ts         <= '0;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        lcg_state = 32'd91;
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        fd = $fopen("tb/tof_hist_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/tof_hist_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                op   = line[0];
                rest = line.substr(1, line.len() - 1);
                ok   = 1'b0;
                case (op)
                    "W", "R": begin
                        if ($sscanf(rest, "%h %h %h", addr, data, err) == 3) begin
                            apb_access(op == "W", addr, data, err);
                            ok = 1'b1;
                        end
                    end
                    "A": begin
                        if ($sscanf(rest, "%d %d %h %h %h %h",
                                    gapped, reps, w0, w1, w2, w3) == 6) begin
                            repeat (reps) send_acq(gapped != 0, {w0, w1, w2, w3});
                            ok = 1'b1;
                        end
                    end
                    "D": begin
                        if ($sscanf(rest, "%d", lat) == 1) begin
                            wait_frame_done(lat);
                            ok = 1'b1;
                        end
                    end
                    default: ok = 1'b0;
                endcase
                if (!ok) begin
                    $display("unreadable line in the tests file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tof_hist_top.f ====
+incdir+hdl
hdl/tof_hist_pkg.sv
hdl/sample_binner.sv
hdl/hist_accumulator.sv
hdl/peak_finder.sv
hdl/hist_apb_regs.sv
hdl/tof_hist_top.sv
tb/tof_hist_assertions.sv
tb/tof_hist_tb.sv

// ==== Makefile ====
TOP := tof_hist_tb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

build:
	verilator --binary --timing --assert -f tof_hist_top.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f tof_hist_top.f --top-module tof_hist_top

clean:
	rm -rf obj_dir

// ==== tb/tof_hist_tests.txt ====
# W addr data slverr | R addr expected_data expected_slverr   (all hex)
# A gapped reps pix0 pix1 pix2 pix3 (four timestamps per pixel) | D frame_done latency
# frame 1: coarse, back to back, forwarding and first-reach ties
W 00 00000001 0
A 0 3 35373a52 71a2a473 c0c1c2c3 18292a1b
D 4
R 10 00000903 0
R 14 0000060a 0
R 18 00000c0c 0
R 1c 00000602 0
R 04 00000101 0
W 04 00000001 0
R 04 00000100 0
R 00 00000001 0
R 08 00000000 1
W 20 deadbeef 1
# frame 2: fine, only samples inside the stored coarse peak, random gaps
W 00 00000003 0
A 1 3 35373745 a9a9b971 12345678 2f2e2f20
D 4
R 10 00000673 0
R 14 0000069a 0
R 18 0000000c 0
R 1c 000006f2 0
R 04 00000201 0
# frame 3: coarse again, fine written mid-frame, one disabled acquisition dropped
W 00 00000001 0
A 0 1 31525354 a0111213 c5c6d0d1 2f2f2f2f
W 00 00000003 0
A 1 1 31525354 a0111213 c5c6d0d1 2f2f2f2f
W 00 00000002 0
A 0 1 ffffffff ffffffff ffffffff ffffffff
W 00 00000003 0
A 0 1 31525354 a0111213 c5c6d0d1 2f2f2f2f
D 4
R 10 00000975 0
R 14 00000991 0
R 18 0000060c 0
R 1c 00000cf2 0
R 04 00000301 0
W 04 00000001 0
R 04 00000300 0
R 00 00000003 0
